// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_clocks_reset \
		-f verilog.f --Mdir obj_dir -o sim
	./obj_dir/sim > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/tb_clocks_reset.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clocks_reset;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int XFER_MAX = 5; // setup, access, idle and slack.
	localparam int DIV_READS = 24;
	localparam int DIV_GAP_MAX = 256;
	localparam int CLEAR_ROUNDS = 16;
	localparam int RW_ROUNDS = 16;
	localparam int RATE0_RUN = 3072;
	localparam int RATE_RUN = 2048;
	localparam int FRAME_RUN = 32768;
	localparam int TEST_CYCLES = RESET_CYCLES + DIV_READS * (DIV_GAP_MAX + XFER_MAX)
		+ CLEAR_ROUNDS * (16 + 3 * XFER_MAX) + RW_ROUNDS * 7 * XFER_MAX
		+ RATE0_RUN + 3 * RATE_RUN + 4 * (4 * XFER_MAX + 40) + FRAME_RUN + 600;
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD; // twice the test length.

	logic clkin_a;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [1:0] paddr;
	logic [7:0] pwdata;
	logic [7:0] prdata;
	logic pready;
	logic phi_out;
	logic timer_irq;
	logic tick_512hz;
	logic tick_256hz;
	logic tick_128hz;

	// model state, valid between clock edges.
	logic [15:0] m_count;
	logic [7:0] m_tima;
	logic [7:0] m_tma;
	logic [7:0] m_tac;
	logic m_gated_prev;
	logic m_frame_prev;
	logic m_irq;
	logic m_t512;
	logic m_t256;
	logic m_t128;
	logic m_phi;
	logic m_prev_setup;
	int m_falls;
	logic model_valid = 1'b0;

	int checks = 0;
	int errors = 0;
	int failures = 0;
	int cycle = 0;
	int irq_count = 0;
	int cnt_512 = 0;
	int cnt_256 = 0;
	int cnt_128 = 0;

	clocks_reset_top uut (
		.clkin_a(clkin_a), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready),
		.phi_out(phi_out), .timer_irq(timer_irq),
		.tick_512hz(tick_512hz), .tick_256hz(tick_256hz), .tick_128hz(tick_128hz)
	);

	initial clkin_a = 1'b0;
	always #(CLK_PERIOD / 2) clkin_a = ~clkin_a;

	// counter bit behind each tac rate code.
	function automatic int tap_index(input logic [1:0] rate);
		case (rate)
			2'd0: return 9;
			2'd1: return 3;
			2'd2: return 5;
			default: return 7;
		endcase
	endfunction

	function automatic void reset_model();
		m_count = '0;
		m_tima = '0;
		m_tma = '0;
		m_tac = '0;
		{m_gated_prev, m_frame_prev, m_irq, m_phi, m_prev_setup} = '0;
		{m_t512, m_t256, m_t128} = '0;
		m_falls = 0;
	endfunction

	// one clkin_a edge of counter, timer and frame sequencer.
	function automatic void step_model(input logic wr_div, input logic wr_tima,
		input logic wr_tma, input logic wr_tac, input logic [7:0] wd, input logic setup_now);
		logic gated_now;
		logic tima_inc;
		logic frame_fall;
		gated_now = m_tac[2] && m_count[tap_index(m_tac[1:0])];
		tima_inc = m_gated_prev && !gated_now;
		frame_fall = m_frame_prev && !m_count[12];
		m_irq = tima_inc && (m_tima == 8'hff) && !wr_tima;
		if (wr_tima)
			m_tima = wd;
		else if (tima_inc)
			m_tima = (m_tima == 8'hff) ? m_tma : m_tima + 8'd1;
		if (wr_tma)
			m_tma = wd;
		if (wr_tac)
			m_tac = wd & 8'h07;
		if (frame_fall)
			m_falls++;
		m_t512 = frame_fall;
		m_t256 = frame_fall && (m_falls % 2 == 0);
		m_t128 = frame_fall && (m_falls % 4 == 0);
		m_gated_prev = gated_now;
		m_frame_prev = m_count[12];
		m_phi = m_count[1];
		m_count = wr_div ? 16'h0000 : m_count + 16'd1;
		m_prev_setup = setup_now;
	endfunction

	function automatic logic [7:0] expected_read(input logic [1:0] addr);
		case (addr)
			2'd0: return m_count[15:8];
			2'd1: return m_tima;
			2'd2: return m_tma;
			default: return m_tac | 8'hf8;
		endcase
	endfunction

	function automatic void check_value(input string what, input logic [7:0] got,
		input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
		end
	endfunction

	// outputs still hold the values of the cycle that this edge ends.
	always @(posedge clkin_a) begin
		logic access;
		logic wr;
		access = m_prev_setup && psel && penable;
		wr = access && pwrite;
		if (model_valid) begin
			check_value("tick_512hz", {7'd0, tick_512hz}, {7'd0, m_t512});
			check_value("tick_256hz", {7'd0, tick_256hz}, {7'd0, m_t256});
			check_value("tick_128hz", {7'd0, tick_128hz}, {7'd0, m_t128});
			check_value("timer_irq", {7'd0, timer_irq}, {7'd0, m_irq});
			check_value("phi_out", {7'd0, phi_out}, {7'd0, m_phi});
			check_value("pready", {7'd0, pready}, {7'd0, access});
			if (access && !pwrite)
				check_value("prdata", prdata, expected_read(paddr));
			cycle++;
			cnt_512 += int'(tick_512hz);
			cnt_256 += int'(tick_256hz);
			cnt_128 += int'(tick_128hz);
			irq_count += int'(timer_irq);
		end
		if (rst) begin
			reset_model();
			model_valid = 1'b1;
		end else begin
			step_model(wr && paddr == 2'd0, wr && paddr == 2'd1, wr && paddr == 2'd2,
				wr && paddr == 2'd3, pwdata, psel && !penable);
		end
	end

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clkin_a);
	endtask

	task automatic transfer(input logic write, input logic [1:0] addr,
		input logic [7:0] wd, output logic [7:0] rd);
		int waited;
		@(negedge clkin_a);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wd;
		@(negedge clkin_a);
		penable = 1'b1;
		waited = 0;
		@(posedge clkin_a);
		while (!pready && waited < 8) begin
			waited++;
			@(posedge clkin_a);
		end
		rd = prdata;
		assert (pready) else begin
			failures++;
			$display("APB transfer to offset %0d never got pready", addr);
		end
		@(negedge clkin_a);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
		logic [7:0] ignored;
		transfer(1'b1, addr, data, ignored);
	endtask

	task automatic read_reg(input logic [1:0] addr, output logic [7:0] data);
		transfer(1'b0, addr, 8'h00, data);
	endtask

	initial begin
		logic [7:0] rd;
		logic [7:0] v;
		logic [7:0] tma_v;
		int start;
		int base_irq;
		int base_512;
		int base_256;
		int base_128;
		void'($urandom(32'hc951));
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 2'd0;
		pwdata = 8'h00;
		repeat (RESET_CYCLES) @(negedge clkin_a);
		rst = 1'b0;

		for (int i = 0; i < DIV_READS; i++) begin
			idle_cycles($urandom % DIV_GAP_MAX);
			read_reg(2'd0, rd);
		end

		// fast tap, cleared at random phases.
		write_reg(2'd3, 8'h05);
		for (int i = 0; i < CLEAR_ROUNDS; i++) begin
			idle_cycles($urandom % 16);
			write_reg(2'd0, 8'($urandom));
			read_reg(2'd0, rd);
			check_value("DIV after clear", rd, 8'h00);
			read_reg(2'd1, rd);
		end

		for (int i = 0; i < RW_ROUNDS; i++) begin
			v = 8'($urandom);
			write_reg(2'd2, v);
			read_reg(2'd2, rd);
			check_value("TMA readback", rd, v);
			v = 8'($urandom);
			write_reg(2'd3, v);
			read_reg(2'd3, rd);
			check_value("TAC readback", rd, v | 8'hf8);
			write_reg(2'd3, v & 8'hfb); // timer off.
			v = 8'($urandom);
			write_reg(2'd1, v);
			read_reg(2'd1, rd);
			check_value("TIMA readback", rd, v);
		end

		// reload values kept high so slow rates still wrap.
		for (int r = 0; r < 4; r++) begin
			write_reg(2'd3, 8'h00);
			case (r)
				0: tma_v = 8'hfe | 8'($urandom % 2);
				1: tma_v = 8'($urandom);
				2: tma_v = 8'hf0 | 8'($urandom % 16);
				default: tma_v = 8'hfc | 8'($urandom % 4);
			endcase
			write_reg(2'd2, tma_v);
			write_reg(2'd1, 8'hff - 8'($urandom % 2));
			base_irq = irq_count;
			start = cycle;
			write_reg(2'd3, 8'h04 | 8'(r));
			while (cycle - start < (r == 0 ? RATE0_RUN : RATE_RUN)) begin
				idle_cycles($urandom % 32);
				read_reg(2'd1, rd);
			end
			assert (irq_count > base_irq) else begin
				failures++;
				$display("No timer interrupt seen at rate code %0d", r);
			end
		end

		// four frame periods, no div writes.
		write_reg(2'd3, 8'h00);
		start = cycle;
		base_512 = cnt_512;
		base_256 = cnt_256;
		base_128 = cnt_128;
		while (cycle - start < FRAME_RUN - 600) begin
			idle_cycles(500 + $urandom % 64);
			read_reg(2'd0, rd);
		end
		while (cycle - start < FRAME_RUN)
			@(negedge clkin_a);
		check_value("512 Hz ticks in window", 8'(cnt_512 - base_512), 8'd4);
		check_value("256 Hz ticks in window", 8'(cnt_256 - base_256), 8'd2);
		check_value("128 Hz ticks in window", 8'(cnt_128 - base_128), 8'd1);

		idle_cycles(4);
		$display("Summary: %0d checks, %0d wrong values, %0d other failures",
			checks, errors, failures);
		if (errors == 0 && failures == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Summary: %0d checks, %0d wrong values, %0d other failures",
			checks, errors, failures);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/clocks_reset_top.sv
`timescale 1ns/1ps
`default_nettype none

module clocks_reset_top (
	input  logic clkin_a,
	input  logic rst,

	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  gb_regs_pkg::reg_addr_t paddr,
	input  gb_regs_pkg::reg_byte_t pwdata,
	output gb_regs_pkg::reg_byte_t prdata,
	output logic pready,

	output logic phi_out,
	output logic timer_irq,
	output logic tick_512hz,
	output logic tick_256hz,
	output logic tick_128hz
);

	gb_clock_pkg::sys_count_t sys_count;
	gb_regs_pkg::reg_byte_t wdata;
	gb_regs_pkg::reg_byte_t tima;
	gb_regs_pkg::reg_byte_t tma;
	gb_regs_pkg::reg_byte_t tac;
	logic div_clear;
	logic tima_we;
	logic tma_we;
	logic tac_we;

	reg_ctrl u_reg_ctrl (
		.clkin_a(clkin_a), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready),
		.sys_count(sys_count), .tima(tima), .tma(tma), .tac(tac),
		.div_clear(div_clear), .tima_we(tima_we), .tma_we(tma_we),
		.tac_we(tac_we), .wdata(wdata)
	);

	div_counter u_div_counter (
		.clkin_a(clkin_a), .rst(rst), .div_clear(div_clear),
		.sys_count(sys_count), .phi_out(phi_out)
	);

	timer_unit u_timer_unit (
		.clkin_a(clkin_a), .rst(rst), .sys_count(sys_count), .wdata(wdata),
		.tima_we(tima_we), .tma_we(tma_we), .tac_we(tac_we),
		.tima(tima), .tma(tma), .tac(tac), .timer_irq(timer_irq)
	);

	frame_seq u_frame_seq (
		.clkin_a(clkin_a), .rst(rst), .sys_count(sys_count),
		.tick_512hz(tick_512hz), .tick_256hz(tick_256hz), .tick_128hz(tick_128hz)
	);

endmodule

`default_nettype wire

// File: src/div_counter.sv
`timescale 1ns/1ps
`default_nettype none

module div_counter (
	input  logic clkin_a,
	input  logic rst,
	input  logic div_clear,

	output gb_clock_pkg::sys_count_t sys_count,
	output logic phi_out
);

	gb_clock_pkg::sys_count_t count_next;

	// a div write restarts the whole chain, not only the visible byte.
	always_comb begin
		if (div_clear)
			count_next = '0;
		else
			count_next = sys_count + 1'b1;
	end

	always_ff @(posedge clkin_a) begin
		if (rst)
			sys_count <= '0;
		else
			sys_count <= count_next;
	end

	// cpu phase, one clock behind the counter bit.
	always_ff @(posedge clkin_a) begin
		if (rst)
			phi_out <= 1'b0;
		else
			phi_out <= sys_count[gb_clock_pkg::PHI_BIT];
	end

	// counter must restart from zero right after the write.
	assert property (@(posedge clkin_a) disable iff (rst)
		div_clear |=> (sys_count == '0));

endmodule

`default_nettype wire

// File: src/frame_seq.sv
`timescale 1ns/1ps
`default_nettype none

module frame_seq (
	input  logic clkin_a,
	input  logic rst,
	input  gb_clock_pkg::sys_count_t sys_count,

	output logic tick_512hz,
	output logic tick_256hz,
	output logic tick_128hz
);

	logic frame_q;
	logic fall;
	logic [1:0] step;

	// a div clear with bit 12 high counts as a falling edge too.
	assign fall = frame_q && !sys_count[gb_clock_pkg::FRAME_BIT];

	always_ff @(posedge clkin_a) begin
		if (rst) begin
			frame_q <= 1'b0;
			step <= 2'd0;
		end else begin
			frame_q <= sys_count[gb_clock_pkg::FRAME_BIT];
			if (fall)
				step <= step + 2'd1;
		end
	end

	always_ff @(posedge clkin_a) begin
		if (rst) begin
			tick_512hz <= 1'b0;
			tick_256hz <= 1'b0;
			tick_128hz <= 1'b0;
		end else begin
			tick_512hz <= fall;
			tick_256hz <= fall && step[0];          // every 2nd.
			tick_128hz <= fall && (step == 2'd3);   // every 4th.
		end
	end

	assert property (@(posedge clkin_a) disable iff (rst)
		tick_128hz |-> (tick_256hz && tick_512hz));

endmodule

`default_nettype wire

// File: src/gb_clock_pkg.sv
`default_nettype none

package gb_clock_pkg;

	localparam int SYS_COUNT_W = 16;

	// free running count of clkin_a edges.
	typedef logic [SYS_COUNT_W-1:0] sys_count_t;

	// div shows the upper byte.
	localparam int DIV_MSB = 15;
	localparam int DIV_LSB = 8;

	localparam int PHI_BIT   = 1;  // 4 MHz / 4.
	localparam int FRAME_BIT = 12; // falling edge at 512 Hz.

	// tac layout.
	localparam int TAC_EN_BIT = 2;

	typedef logic [1:0] timer_sel_t;

	localparam timer_sel_t TIMER_SEL_4096   = 2'd0;
	localparam timer_sel_t TIMER_SEL_262144 = 2'd1;
	localparam timer_sel_t TIMER_SEL_65536  = 2'd2;
	localparam timer_sel_t TIMER_SEL_16384  = 2'd3;

	// counter taps for each rate code.
	localparam int TAP_SEL0 = 9;
	localparam int TAP_SEL1 = 3;
	localparam int TAP_SEL2 = 5;
	localparam int TAP_SEL3 = 7;

endpackage

`default_nettype wire

// File: src/gb_regs_pkg.sv
`default_nettype none

package gb_regs_pkg;

	// one register word on the cpu side.
	typedef logic [7:0] reg_byte_t;

	// offset inside the 0x04..0x07 window.
	typedef logic [1:0] reg_addr_t;

	localparam reg_addr_t ADDR_DIV  = 2'd0; // 0x04
	localparam reg_addr_t ADDR_TIMA = 2'd1; // 0x05
	localparam reg_addr_t ADDR_TMA  = 2'd2; // 0x06
	localparam reg_addr_t ADDR_TAC  = 2'd3; // 0x07

	// tac bits 7..3 are not implemented and read as ones.
	localparam reg_byte_t TAC_UNUSED_MASK = 8'hf8;

	// phase of the bus cycle just sampled.
	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apb_state_t;

endpackage

`default_nettype wire

// File: src/reg_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module reg_ctrl (
	input  logic clkin_a,
	input  logic rst,

	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  gb_regs_pkg::reg_addr_t paddr,
	input  gb_regs_pkg::reg_byte_t pwdata,
	output gb_regs_pkg::reg_byte_t prdata,
	output logic pready,

	input  gb_clock_pkg::sys_count_t sys_count,
	input  gb_regs_pkg::reg_byte_t tima,
	input  gb_regs_pkg::reg_byte_t tma,
	input  gb_regs_pkg::reg_byte_t tac,

	output logic div_clear,
	output logic tima_we,
	output logic tma_we,
	output logic tac_we,
	output gb_regs_pkg::reg_byte_t wdata
);

	gb_regs_pkg::apb_state_t state;
	gb_regs_pkg::apb_state_t state_next;
	logic access;
	logic wr;

	// state holds the phase of the cycle that just ended.
	always_comb begin
		state_next = gb_regs_pkg::APB_IDLE;
		case (state)
			gb_regs_pkg::APB_IDLE,
			gb_regs_pkg::APB_ACCESS: begin
				if (psel && !penable)
					state_next = gb_regs_pkg::APB_SETUP;
			end
			gb_regs_pkg::APB_SETUP: begin
				if (psel && penable)
					state_next = gb_regs_pkg::APB_ACCESS;
				else if (psel)
					state_next = gb_regs_pkg::APB_SETUP;
			end
			default: state_next = gb_regs_pkg::APB_IDLE;
		endcase
	end

	always_ff @(posedge clkin_a) begin
		if (rst)
			state <= gb_regs_pkg::APB_IDLE;
		else
			state <= state_next;
	end

	// access phase always follows a setup, no wait states.
	assign access = (state == gb_regs_pkg::APB_SETUP) && psel && penable;
	assign pready = access;
	assign wr = access && pwrite;

	assign div_clear = wr && (paddr == gb_regs_pkg::ADDR_DIV);
	assign tima_we   = wr && (paddr == gb_regs_pkg::ADDR_TIMA);
	assign tma_we    = wr && (paddr == gb_regs_pkg::ADDR_TMA);
	assign tac_we    = wr && (paddr == gb_regs_pkg::ADDR_TAC);
	assign wdata     = pwdata;

	// reads see the registers before the closing edge.
	always_comb begin
		case (paddr)
			gb_regs_pkg::ADDR_DIV:
				prdata = sys_count[gb_clock_pkg::DIV_MSB:gb_clock_pkg::DIV_LSB];
			gb_regs_pkg::ADDR_TIMA: prdata = tima;
			gb_regs_pkg::ADDR_TMA:  prdata = tma;
			default:                prdata = tac | gb_regs_pkg::TAC_UNUSED_MASK;
		endcase
	end

	// a master must pass through setup before raising penable.
	assert property (@(posedge clkin_a) disable iff (rst)
		$rose(penable) |-> $past(psel));

endmodule

`default_nettype wire

// File: src/timer_unit.sv
`timescale 1ns/1ps
`default_nettype none

module timer_unit (
	input  logic clkin_a,
	input  logic rst,
	input  gb_clock_pkg::sys_count_t sys_count,

	input  gb_regs_pkg::reg_byte_t wdata,
	input  logic tima_we,
	input  logic tma_we,
	input  logic tac_we,

	output gb_regs_pkg::reg_byte_t tima,
	output gb_regs_pkg::reg_byte_t tma,
	output gb_regs_pkg::reg_byte_t tac,
	output logic timer_irq
);

	gb_clock_pkg::timer_sel_t rate;
	logic tap;
	logic gated;
	logic gated_q;
	logic inc;
	logic ovf;

	assign rate = tac[1:0];

	always_comb begin
		case (rate)
			gb_clock_pkg::TIMER_SEL_4096:   tap = sys_count[gb_clock_pkg::TAP_SEL0];
			gb_clock_pkg::TIMER_SEL_262144: tap = sys_count[gb_clock_pkg::TAP_SEL1];
			gb_clock_pkg::TIMER_SEL_65536:  tap = sys_count[gb_clock_pkg::TAP_SEL2];
			gb_clock_pkg::TIMER_SEL_16384:  tap = sys_count[gb_clock_pkg::TAP_SEL3];
			default:                        tap = 1'b0;
		endcase
	end

	// enable gates the tap before the edge detector, so turning the
	// timer off or clearing div while the tap is high also counts.
	assign gated = tac[gb_clock_pkg::TAC_EN_BIT] && tap;
	assign inc = gated_q && !gated;
	assign ovf = inc && (tima == 8'hff);

	always_ff @(posedge clkin_a) begin
		if (rst) begin
			gated_q <= 1'b0;
			timer_irq <= 1'b0;
		end else begin
			gated_q <= gated;
			timer_irq <= ovf && !tima_we; // lost if the cpu writes tima.
		end
	end

	always_ff @(posedge clkin_a) begin
		if (rst) begin
			tima <= '0;
			tma <= '0;
			tac <= '0;
		end else begin
			if (tima_we)
				tima <= wdata;
			else if (ovf)
				tima <= tma; // reload on wrap.
			else if (inc)
				tima <= tima + 1'b1;

			if (tma_we)
				tma <= wdata;

			if (tac_we)
				tac <= wdata & ~gb_regs_pkg::TAC_UNUSED_MASK;
		end
	end

	// with the timer off and no pending fall, only a cpu write moves tima.
	assert property (@(posedge clkin_a) disable iff (rst)
		(!tac[gb_clock_pkg::TAC_EN_BIT] && !gated_q && !tima_we) |=> $stable(tima));

endmodule

`default_nettype wire

// File: verilog.f
src/gb_regs_pkg.sv
src/gb_clock_pkg.sv
src/div_counter.sv
src/timer_unit.sv
src/frame_seq.sv
src/reg_ctrl.sv
src/clocks_reset_top.sv
bench/tb_clocks_reset.sv
